// File: hw/echo_sequencer.sv
// ---------------------------------------------------------------------
// echo sequencer
// two-entry rx queue with overflow detect, echo fsm,
// credit counter towards the transmitter, status leds
// ---------------------------------------------------------------------

module echo_sequencer (
	input  logic clk27,
	input  logic rst,
	input  serial_echo_pkg::rx_char_t rx_char,
	input  logic frame_err,
	input  logic mode_bin,
	output serial_echo_pkg::tx_req_t tx_req,
	input  logic credit_ret,
	output logic [2:0] led
);
	import serial_echo_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_send_char,
		st_send_space,
		st_send_bits,
		st_send_cr,
		st_send_nl
	} echo_state_t;

	echo_state_t state;

	// ------------------------------------------------------------------
	// rx queue
	// ------------------------------------------------------------------
	logic [char_bits-1:0] q_mem [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] q_count;
	logic push_ok;
	logic pop;
	// character being echoed, stays queued until ch_nl is loaded
	logic [char_bits-1:0] head;

	// echo control
	logic mode_q;
	logic [$clog2(char_bits)-1:0] bit_idx;
	logic [1:0] credit_cnt;
	logic has_credit;
	logic send_now;
	logic [char_bits-1:0] send_data;

	// sticky status
	logic overflow;
	logic frame_seen;

	// full queue drops the character
	assign push_ok = rx_char.valid && (q_count != 2'd2);
	assign pop = send_now && (state == st_send_nl);
	assign head = q_mem[rd_ptr];

	always_ff @(posedge clk27) begin
		if (push_ok)
			q_mem[wr_ptr] <= rx_char.data;
	end

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			q_count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			q_count <= q_count + {1'b0, push_ok} - {1'b0, pop};
		end
	end

	// ------------------------------------------------------------------
	// credit towards serial_tx, one slot
	// ------------------------------------------------------------------
	assign has_credit = (credit_cnt == 2'd1);
	assign send_now = (state != st_idle) && has_credit;

	always_ff @(posedge clk27, posedge rst) begin
		if (rst)
			credit_cnt <= 2'd1;
		else
			credit_cnt <= credit_cnt + {1'b0, credit_ret} - {1'b0, tx_req.load};
	end

	// ------------------------------------------------------------------
	// echo fsm
	// ------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= st_idle;
			mode_q <= 1'b0;
			bit_idx <= '0;
		end else begin
			unique case (state)
				st_idle: begin
					if (q_count != 2'd0) begin
						// mode is frozen for the whole echo
						mode_q <= mode_bin;
						state <= st_send_char;
					end
				end
				st_send_char: begin
					if (send_now)
						state <= mode_q ? st_send_space : st_send_cr;
				end
				st_send_space: begin
					if (send_now) begin
						bit_idx <= $bits(bit_idx)'(char_bits - 1);
						state <= st_send_bits;
					end
				end
				st_send_bits: begin
					// high bit first
					if (send_now) begin
						if (bit_idx == '0)
							state <= st_send_cr;
						else
							bit_idx <= bit_idx - 1'b1;
					end
				end
				st_send_cr: begin
					if (send_now)
						state <= st_send_nl;
				end
				st_send_nl: begin
					if (send_now)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// byte for the current state
	always_comb begin
		send_data = ch_space;
		unique case (state)
			st_send_char: send_data = head;
			st_send_bits: send_data = ch_zero | {{(char_bits - 1){1'b0}}, head[bit_idx]};
			st_send_cr: send_data = ch_cr;
			st_send_nl: send_data = ch_nl;
			default: send_data = ch_space;
		endcase
	end

	assign tx_req = '{load: send_now, data: send_data};

	// ------------------------------------------------------------------
	// status
	// ------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			overflow <= 1'b0;
			frame_seen <= 1'b0;
		end else begin
			if (rx_char.valid && !push_ok)
				overflow <= 1'b1;
			if (frame_err)
				frame_seen <= 1'b1;
		end
	end

	assign led = {frame_seen, overflow, mode_bin};

endmodule

// File: hw/key_toggle.sv
// ---------------------------------------------------------------------
// mode key conditioner
// synchronizer, debounce counter, toggle on each press
// ---------------------------------------------------------------------

module key_toggle (
	input  logic clk27,
	input  logic rst,
	input  logic mode_key,
	output logic mode_bin
);
	import serial_echo_pkg::*;

	logic key_meta;
	logic key_sync;
	// key is active low on the board
	logic pressed;
	// level accepted after debounce
	logic key_level;
	logic [$clog2(debounce_cycles)-1:0] db_cnt;
	logic accept;

	// synchronizer, released key reads high
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			key_meta <= 1'b1;
			key_sync <= 1'b1;
		end else begin
			key_meta <= mode_key;
			key_sync <= key_meta;
		end
	end

	assign pressed = ~key_sync;
	// new level held long enough
	assign accept = (pressed != key_level)
		&& (db_cnt == $bits(db_cnt)'(debounce_cycles - 1));

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			db_cnt <= '0;
			key_level <= 1'b0;
			mode_bin <= 1'b0;
		end else begin
			// any bounce back to the old level restarts the count
			if (pressed == key_level || accept)
				db_cnt <= '0;
			else
				db_cnt <= db_cnt + 1'b1;
			if (accept) begin
				key_level <= pressed;
				// flip on press only, release is ignored
				if (pressed)
					mode_bin <= ~mode_bin;
			end
		end
	end

endmodule

// File: hw/serial_echo_pkg.sv
// ---------------------------------------------------------------------
// shared definitions for the serial echo unit
// rate constants, ascii character codes, rx and tx structs
// ---------------------------------------------------------------------

package serial_echo_pkg;

	// ------------------------------------------------------------------
	// rates
	// ------------------------------------------------------------------
	// board clock
	localparam int main_clk_hz = 27_000_000;
	// nominal line rate
	localparam int serial_clk_hz = 115_200;
	// sample ticks per bit
	localparam int oversample = 16;
	// clocks per sample tick, rounded to nearest, gives 15
	localparam int tick_cycles = (main_clk_hz + serial_clk_hz * oversample / 2)
		/ (serial_clk_hz * oversample);
	// mid-bit sample tick
	localparam int sample_point = 8;
	// data bits per character
	localparam int char_bits = 8;
	// cycles a new key level must hold
	localparam int debounce_cycles = 1024;

	// ------------------------------------------------------------------
	// ascii codes used by the echo
	// ------------------------------------------------------------------
	localparam logic [char_bits-1:0] ch_space = 8'h20;
	localparam logic [char_bits-1:0] ch_zero = 8'h30;
	localparam logic [char_bits-1:0] ch_cr = 8'h0d;
	localparam logic [char_bits-1:0] ch_nl = 8'h0a;

	// received character, valid is a one-cycle strobe
	typedef struct packed {
		logic valid;
		logic [char_bits-1:0] data;
	} rx_char_t;

	// transmit request, load spends the credit
	typedef struct packed {
		logic load;
		logic [char_bits-1:0] data;
	} tx_req_t;

endpackage

// File: hw/serial_echo_top.sv
// ---------------------------------------------------------------------
// serial echo top level
// receiver and key conditioner feed the echo sequencer,
// which drives the transmitter
// ---------------------------------------------------------------------

module serial_echo_top (
	input  logic clk27,
	input  logic rst,
	input  logic serial_rx,
	output logic serial_tx,
	input  logic mode_key,
	output logic [2:0] led
);
	import serial_echo_pkg::*;

	rx_char_t rx_char;
	logic frame_err;
	logic mode_bin;
	// credit link towards the transmitter
	tx_req_t tx_req;
	logic credit_ret;

	serial_rx rx_inst (
		.clk27(clk27),
		.rst(rst),
		.serial_in(serial_rx),
		.rx_char(rx_char),
		.frame_err(frame_err)
	);

	key_toggle key_inst (
		.clk27(clk27),
		.rst(rst),
		.mode_key(mode_key),
		.mode_bin(mode_bin)
	);

	echo_sequencer seq_inst (
		.clk27(clk27),
		.rst(rst),
		.rx_char(rx_char),
		.frame_err(frame_err),
		.mode_bin(mode_bin),
		.tx_req(tx_req),
		.credit_ret(credit_ret),
		.led(led)
	);

	serial_tx tx_inst (
		.clk27(clk27),
		.rst(rst),
		.tx_req(tx_req),
		.credit_ret(credit_ret),
		.serial_out(serial_tx)
	);

endmodule

// File: hw/serial_rx.sv
// ---------------------------------------------------------------------
// oversampling asynchronous receiver
// 8 data bits low bit first, one stop bit, no parity
// start bit confirmation and stop bit framing check
// ---------------------------------------------------------------------

module serial_rx (
	input  logic clk27,
	input  logic rst,
	input  logic serial_in,
	output serial_echo_pkg::rx_char_t rx_char,
	output logic frame_err
);
	import serial_echo_pkg::*;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	rx_state_t state;

	// line synchronizer
	logic line_meta;
	logic line_sync;

	// tick divider and position inside the bit
	logic [$clog2(tick_cycles)-1:0] div_cnt;
	logic [$clog2(oversample)-1:0] tick_cnt;
	logic tick;
	logic sample;

	logic [$clog2(char_bits)-1:0] bit_cnt;
	logic [char_bits-1:0] shift_data;
	logic char_valid;

	// ------------------------------------------------------------------
	// two flop synchronizer, idle line is high
	// ------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
		end else begin
			line_meta <= serial_in;
			line_sync <= line_meta;
		end
	end

	// ------------------------------------------------------------------
	// sample timing
	// ------------------------------------------------------------------
	assign tick = (div_cnt == $bits(div_cnt)'(tick_cycles - 1));
	// centre of the bit, half a bit after the start edge
	assign sample = tick && (tick_cnt == $bits(tick_cnt)'(sample_point - 1));

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			div_cnt <= '0;
			tick_cnt <= '0;
		end else if (state == rx_idle) begin
			// held at zero so a frame starts aligned to its edge
			div_cnt <= '0;
			tick_cnt <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			// wraps every oversample ticks, i.e. once per bit
			if (tick)
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// frame fsm
	// ------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= rx_idle;
			bit_cnt <= '0;
			char_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			// strobes by default
			char_valid <= 1'b0;
			frame_err <= 1'b0;
			unique case (state)
				rx_idle: begin
					if (!line_sync)
						state <= rx_start;
				end
				rx_start: begin
					if (sample) begin
						// line high again at mid start bit, just a glitch
						if (line_sync) begin
							state <= rx_idle;
						end else begin
							bit_cnt <= '0;
							state <= rx_data;
						end
					end
				end
				rx_data: begin
					if (sample) begin
						if (bit_cnt == $bits(bit_cnt)'(char_bits - 1))
							state <= rx_stop;
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (sample) begin
						// bad stop bit, character is thrown away
						char_valid <= line_sync;
						frame_err <= !line_sync;
						state <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// data shifter, low bit arrives first
	always_ff @(posedge clk27) begin
		if (state == rx_data && sample)
			shift_data <= {line_sync, shift_data[char_bits-1:1]};
	end

	assign rx_char = '{valid: char_valid, data: shift_data};

endmodule

// File: hw/serial_tx.sv
// ---------------------------------------------------------------------
// serial transmitter
// one-byte slot in front of a 10-bit shifter, credit return
// when the slot moves into the shifter
// ---------------------------------------------------------------------

module serial_tx (
	input  logic clk27,
	input  logic rst,
	input  serial_echo_pkg::tx_req_t tx_req,
	output logic credit_ret,
	output logic serial_out
);
	import serial_echo_pkg::*;

	// buffer slot
	logic slot_full;
	logic [char_bits-1:0] slot_data;

	// stop, data, start; bit 0 drives the line
	logic [char_bits+1:0] shifter;
	logic busy;

	logic [$clog2(tick_cycles)-1:0] div_cnt;
	logic [$clog2(oversample)-1:0] tick_cnt;
	logic [$clog2(char_bits + 2)-1:0] bit_cnt;
	logic tick;
	logic bit_end;
	logic start_shift;

	assign tick = (div_cnt == $bits(div_cnt)'(tick_cycles - 1));
	assign bit_end = tick && (tick_cnt == $bits(tick_cnt)'(oversample - 1));
	assign start_shift = !busy && slot_full;

	// ------------------------------------------------------------------
	// slot
	// ------------------------------------------------------------------
	always_ff @(posedge clk27) begin
		if (tx_req.load)
			slot_data <= tx_req.data;
	end

	always_ff @(posedge clk27, posedge rst) begin
		if (rst)
			slot_full <= 1'b0;
		else if (tx_req.load)
			slot_full <= 1'b1;
		else if (start_shift)
			slot_full <= 1'b0;
	end

	// ------------------------------------------------------------------
	// shifter and bit timing
	// ------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			// all ones keeps the line at idle level
			shifter <= '1;
			busy <= 1'b0;
			div_cnt <= '0;
			tick_cnt <= '0;
			bit_cnt <= '0;
			credit_ret <= 1'b0;
		end else begin
			// slot is free again, give the credit back
			credit_ret <= start_shift;
			if (start_shift) begin
				shifter <= {1'b1, slot_data, 1'b0};
				busy <= 1'b1;
				div_cnt <= '0;
				tick_cnt <= '0;
				bit_cnt <= '0;
			end else if (busy) begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick)
					tick_cnt <= tick_cnt + 1'b1;
				if (bit_end) begin
					// fill with ones, line rests high after the stop bit
					shifter <= {1'b1, shifter[char_bits+1:1]};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == $bits(bit_cnt)'(char_bits + 1))
						busy <= 1'b0;
				end
			end
		end
	end

	assign serial_out = shifter[0];

endmodule

// File: serial_echo.f
hw/serial_echo_pkg.sv
hw/serial_rx.sv
hw/key_toggle.sv
hw/echo_sequencer.sv
hw/serial_tx.sv
hw/serial_echo_top.sv
sim/serial_echo_properties.sv
sim/serial_echo_tb.sv

// File: sim/serial_echo_properties.sv
// ---------------------------------------------------------------------
// concurrent checks for the echo sequencer and the transmitter
// credit use, idle line level, sticky status leds
// ---------------------------------------------------------------------

module serial_echo_properties (
	input logic clk27,
	input logic rst,
	input logic load,
	input logic [1:0] credit_cnt,
	input logic credit_ret,
	input logic busy,
	input logic line,
	input logic [2:0] led
);
	// failures seen so far, read by the testbench
	int fail_count = 0;
	// credit as seen on the link, spent by load, back on credit_ret
	logic credit_held;

	always_ff @(posedge clk27, posedge rst) begin
		if (rst)
			credit_held <= 1'b1;
		else if (load)
			credit_held <= 1'b0;
		else if (credit_ret)
			credit_held <= 1'b1;
	end

	// a load spends the one credit
	load_needs_credit: assert property (@(posedge clk27) disable iff (rst)
		load |-> credit_held)
		else begin
			fail_count++;
			$error("tx load issued while no credit was held");
		end

	// returned credit must never push the count past one
	credit_max_one: assert property (@(posedge clk27) disable iff (rst)
		(3'(credit_cnt) + 3'(credit_ret)) <= 3'd1)
		else begin
			fail_count++;
			$error("credit count would exceed one");
		end

	// idle transmitter rests high
	idle_line_high: assert property (@(posedge clk27) disable iff (rst)
		!busy |-> line)
		else begin
			fail_count++;
			$error("serial line low while the transmitter is idle");
		end

	// overflow and framing lights only ever set
	led_sticky: assert property (@(posedge clk27) disable iff (rst)
		(led[2:1] & $past(led[2:1])) == $past(led[2:1]))
		else begin
			fail_count++;
			$error("a sticky status led was cleared");
		end

endmodule

// ---------------------------------------------------------------------
// attach points
// ---------------------------------------------------------------------
bind echo_sequencer serial_echo_properties seq_props (
	.clk27(clk27),
	.rst(rst),
	.load(tx_req.load),
	.credit_cnt(credit_cnt),
	.credit_ret(credit_ret),
	// line level belongs to the transmitter side
	.busy(1'b1),
	.line(1'b1),
	.led(led)
);

bind serial_tx serial_echo_properties tx_props (
	.clk27(clk27),
	.rst(rst),
	// credit side checked in the sequencer
	.load(1'b0),
	.credit_cnt(2'd0),
	.credit_ret(1'b0),
	.busy(busy),
	.line(serial_out),
	.led(3'b000)
);

// File: sim/serial_echo_tb.sv
// ---------------------------------------------------------------------
// testbench for the serial echo unit
// clock and reset, serial line driver, echo line decoder,
// reference echo builder, five tests, timeout
// ---------------------------------------------------------------------

module serial_echo_tb;

	// one bit on the line in clock cycles, start + 8 data + stop per char
	localparam int bit_cycles = 240;
	localparam int char_cycles = bit_cycles * 10;
	// reset, plain, binary, overflow, framing
	localparam int test_chars = 1 + 17 + 18 + 30 + 17;
	localparam int cycle_limit = test_chars * char_cycles * 12 / 10;

	logic clk27;
	logic rst;
	logic rx_line;
	logic tx_line;
	logic mode_key;
	logic [2:0] led;

	// decoded echo bytes and the reference for them
	logic [7:0] got_bytes [$];
	logic [7:0] exp_bytes [$];

	int cycles;
	int errors;
	int tests_run;
	int tests_failed;
	int prop_errors;

	serial_echo_top UUT (
		.clk27(clk27),
		.rst(rst),
		.serial_rx(rx_line),
		.serial_tx(tx_line),
		.mode_key(mode_key),
		.led(led)
	);

	initial begin
		clk27 = 1'b0;
		forever #2 clk27 = ~clk27;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk27);
			cycles++;
		end
		$display("timeout: the echo did not finish within %0d cycles", cycle_limit);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk27);
	endtask

	// ------------------------------------------------------------------
	// line driver
	// ------------------------------------------------------------------
	// a bad stop bit is cut short, so its tail cannot pass as a start bit
	task automatic send_frame(input logic [7:0] data, input logic stop_ok);
		rx_line = 1'b0;
		wait_cycles(bit_cycles);
		for (int i = 0; i < 8; i++) begin
			rx_line = data[i];
			wait_cycles(bit_cycles);
		end
		if (stop_ok) begin
			rx_line = 1'b1;
			wait_cycles(bit_cycles);
		end else begin
			rx_line = 1'b0;
			wait_cycles(bit_cycles * 5 / 8);
			rx_line = 1'b1;
			wait_cycles(bit_cycles * 3 / 8);
		end
	endtask

	// ------------------------------------------------------------------
	// echo line decoder, samples at bit centres
	// ------------------------------------------------------------------
	initial begin : line_decoder
		logic [7:0] data;
		forever begin
			@(negedge tx_line);
			wait_cycles(bit_cycles / 2);
			for (int i = 0; i < 8; i++) begin
				wait_cycles(bit_cycles);
				data[i] = tx_line;
			end
			wait_cycles(bit_cycles);
			assert (tx_line === 1'b1) else begin
				$display("echo line: stop bit sampled low");
				errors++;
			end
			got_bytes.push_back(data);
		end
	end

	// reference echo: byte, [space, 8 digits high bit first], cr, lf
	task automatic add_echo(input logic [7:0] data, input logic bin);
		exp_bytes.push_back(data);
		if (bin) begin
			exp_bytes.push_back(8'h20);
			for (int i = 7; i >= 0; i--)
				exp_bytes.push_back(data[i] ? 8'h31 : 8'h30);
		end
		exp_bytes.push_back(8'h0d);
		exp_bytes.push_back(8'h0a);
	endtask

	task automatic check_echo(input string name);
		logic [7:0] exp;
		logic [7:0] got;
		while (got_bytes.size() < exp_bytes.size())
			@(negedge clk27);
		// quiet line afterwards, nothing extra may follow
		wait_cycles(2 * char_cycles);
		assert (got_bytes.size() == exp_bytes.size()) else begin
			$display("error %s: expected %0d echo bytes, got %0d", name,
				exp_bytes.size(), got_bytes.size());
			errors++;
		end
		while (exp_bytes.size() > 0 && got_bytes.size() > 0) begin
			exp = exp_bytes.pop_front();
			got = got_bytes.pop_front();
			assert (got == exp) else begin
				$display("error %s: expected %02h, got %02h", name, exp, got);
				errors++;
			end
		end
		exp_bytes.delete();
		got_bytes.delete();
	endtask

	task automatic check_led(input string name, input int idx, input logic exp);
		assert (led[idx] === exp) else begin
			$display("error %s: expected led[%0d] %b, got %b", name, idx, exp, led[idx]);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - err_before);
		end
	endtask

	// ------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------
	initial begin : stimulus
		logic [7:0] data;
		int err_before;
		void'($urandom(71939));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b1;
		rx_line = 1'b1;
		mode_key = 1'b1;
		wait_cycles(3);
		rst = 1'b0;
		wait_cycles(4);

		err_before = errors;
		assert (tx_line === 1'b1) else begin
			$display("error reset: expected serial_tx 1, got %b", tx_line);
			errors++;
		end
		assert (led === 3'b000) else begin
			$display("error reset: expected led 000, got %b", led);
			errors++;
		end
		report_test("reset", err_before);

		// plain mode, one character gap between frames
		err_before = errors;
		for (int i = 0; i < 3; i++) begin
			data = 8'($urandom);
			add_echo(data, 1'b0);
			send_frame(data, 1'b1);
			wait_cycles(char_cycles);
		end
		check_echo("plain_echo");
		report_test("plain_echo", err_before);

		// glitch, then a real press and release
		err_before = errors;
		mode_key = 1'b0;
		wait_cycles(500);
		mode_key = 1'b1;
		wait_cycles(1200);
		check_led("binary_echo", 0, 1'b0);
		mode_key = 1'b0;
		wait_cycles(1200);
		check_led("binary_echo", 0, 1'b1);
		mode_key = 1'b1;
		wait_cycles(1200);
		check_led("binary_echo", 0, 1'b1);
		data = 8'($urandom);
		add_echo(data, 1'b1);
		send_frame(data, 1'b1);
		check_echo("binary_echo");
		report_test("binary_echo", err_before);

		// back to back frames, queue holds two
		err_before = errors;
		for (int i = 0; i < 4; i++) begin
			data = 8'($urandom);
			if (i < 2)
				add_echo(data, 1'b1);
			send_frame(data, 1'b1);
		end
		check_echo("overflow");
		check_led("overflow", 1, 1'b1);
		report_test("overflow", err_before);

		// bad stop bit, then a good frame
		err_before = errors;
		send_frame(8'($urandom), 1'b0);
		wait_cycles(2 * bit_cycles);
		check_led("framing", 2, 1'b1);
		data = 8'($urandom);
		add_echo(data, 1'b1);
		send_frame(data, 1'b1);
		check_echo("framing");
		report_test("framing", err_before);

		prop_errors = UUT.seq_inst.seq_props.fail_count + UUT.tx_inst.tx_props.fail_count;
		$display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, prop_errors);
		if (errors == 0 && tests_failed == 0 && prop_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
